// ==== include/hub_macros.svh ====
`ifndef HUB_MACROS_SVH
`define HUB_MACROS_SVH

// Upper address nibble of the hub register space (0x1xxx)
`define HUB_ADDR_SPACE 4'h1

// Hub memory size in quadlets
`define HUB_MEM_DEPTH 512

// Timer value at which the first board in the mask broadcasts
// About 3 us at the system clock rate
`define HUB_FIRST_DELAY 150

// FireWire broadcast trigger enabled unless overridden
`define HUB_USE_FW_DEFAULT 1

// Query register offset inside the hub space (0x1800)
`define HUB_QUERY_OFFSET 12'h800

`endif

// ==== rtl/hub_bus_pkg.sv ====
package hub_bus_pkg;

    // Register bus address, full 16-bit space
    typedef logic [15:0] reg_addr_t;

    // Register bus data word (one quadlet)
    typedef logic [31:0] reg_data_t;

    // Quadlet index within one real-time block
    // Lower byte of a 0x10NN address
    typedef logic [7:0] quad_idx_t;

    // Write request as seen from the register bus
    typedef struct packed {
        logic      wen;    // Single-cycle write strobe
        reg_addr_t waddr;  // Target address
        reg_data_t wdata;  // Quadlet to write
    } bus_wr_t;            // 49 bits

    // Quadlet index of the header and of the status word in a block
    localparam quad_idx_t IDX_HEADER = 8'd0;
    localparam quad_idx_t IDX_STATUS = 8'd2;

    // Index value after a query, so that index 0 is always new
    localparam quad_idx_t IDX_NONE   = 8'hff;

    // Status register offsets (low two bits of 0x1800 to 0x1803)
    localparam logic [1:0] STAT_QUERY   = 2'd0;  // Sequence and mask
    localparam logic [1:0] STAT_OFFSET  = 2'd1;  // Last index and offset
    localparam logic [1:0] STAT_NUMWR   = 2'd2;  // Quadlets written
    localparam logic [1:0] STAT_BOARDID = 2'd3;  // Board id and lower mask

endpackage

// ==== rtl/hub_bcast_pkg.sv ====
package hub_bcast_pkg;

    typedef logic [3:0]  board_id_t;    // Board number on the bus
    typedef logic [15:0] board_mask_t;  // One bit per board id
    typedef logic [15:0] seq_t;         // Query sequence number from the PC
    typedef logic [13:0] bc_time_t;     // Cycles since the last query
    typedef logic [8:0]  mem_addr_t;    // Hub memory quadlet address

    // Header quadlet as stored in hub memory
    // Replaces the header the board sent
    typedef struct packed {
        logic [7:0] blk_size;   // Block size in quadlets, header included
        logic [7:0] seq_lsb;    // Low byte of the sequence the board saw
        logic       seq_error;  // Full sequence did not match the query
        logic       rsvd;       // Always zero
        bc_time_t   upd_time;   // Arrival time relative to the query
    } hub_hdr_t;                // 32 bits

    // Fields of the broadcast query write to 0x1800
    typedef struct packed {
        seq_t        seq;         // Bits 31:16
        board_mask_t board_mask;  // Bits 15:0
    } query_t;

    // Broadcast trigger FSM
    typedef enum logic [1:0] {
        TRIG_IDLE,        // Waiting for a query
        TRIG_WAIT_FIRST,  // Lowest selected board, wait for the fixed delay
        TRIG_WAIT_LOWER,  // Wait for all lower boards to report
        TRIG_DONE         // Triggered or not selected, hold until next query
    } trig_state_t;

endpackage

// ==== rtl/hub_mem.sv ====
`include "hub_macros.svh"

module hub_mem
    import hub_bus_pkg::*;
    import hub_bcast_pkg::*;
(
    input  logic      sysclk,
    input  logic      wen,    // Write strobe from the write control
    input  mem_addr_t waddr,  // Packed block address
    input  reg_data_t wdata,  // Raw quadlet or rewritten header
    input  mem_addr_t raddr,  // Held by the requester for two cycles
    output reg_data_t rdata   // Valid one cycle after raddr
);

    // Block RAM array, contents undefined until written
    reg_data_t mem [`HUB_MEM_DEPTH];
    reg_data_t rdata_q;

    // Port A, write only
    always_ff @(posedge sysclk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // Port B, read only with output register
    always_ff @(posedge sysclk) begin
        rdata_q <= mem[raddr];
    end

    assign rdata = rdata_q;

endmodule

// ==== rtl/hub_write_ctrl.sv ====
`include "hub_macros.svh"

module hub_write_ctrl
    import hub_bus_pkg::*;
    import hub_bcast_pkg::*;
(
    input  logic        sysclk,
    input  logic        write_trig_reset,
    input  bus_wr_t     bus_wr,
    input  bc_time_t    bc_time,        // Stamped into each header
    output query_t      query,          // Latched sequence and mask
    output logic        query_pulse,    // High in the write cycle of 0x1800
    output board_mask_t board_updated,  // Boards whose status word arrived
    output mem_addr_t   num_written,
    output quad_idx_t   last_idx,
    output mem_addr_t   blk_offset,     // Start of the current block
    output logic        mem_wen,
    output mem_addr_t   mem_waddr,
    output reg_data_t   mem_wdata
);

    logic      hub_wen;       // Any write into the hub space
    logic      mem_sel;       // 0x10NN memory write
    logic      new_idx;       // Index differs from the last one seen
    quad_idx_t wr_idx;        // NN of the current write
    quad_idx_t blk_size;      // Size of the block being received
    logic      offset_moved;  // Offset already advanced for this header
    mem_addr_t last_waddr;    // Highest packed address written
    mem_addr_t write_addr;
    hub_hdr_t  hdr;
    board_id_t stat_board;    // Board id carried in the status word

    assign wr_idx     = bus_wr.waddr[7:0];
    assign stat_board = board_id_t'(bus_wr.wdata[27:24]);

    assign hub_wen     = bus_wr.wen && (bus_wr.waddr[15:12] == `HUB_ADDR_SPACE);
    assign query_pulse = hub_wen && (bus_wr.waddr[11:0] == `HUB_QUERY_OFFSET);
    assign mem_sel     = hub_wen && (bus_wr.waddr[11:8] == 4'd0);
    assign new_idx     = (wr_idx != last_idx);

    // Header goes right after the previous block, anything else is relative to
    // the new offset. A repeated header lands on the same place again
    always_comb begin
        if ((wr_idx == IDX_HEADER) && !offset_moved) begin
            write_addr = blk_offset + mem_addr_t'(blk_size);
        end else begin
            write_addr = blk_offset + mem_addr_t'(wr_idx);
        end
    end

    // Header rewrite
    always_comb begin
        hdr.blk_size  = bus_wr.wdata[7:0];
        hdr.seq_lsb   = bus_wr.wdata[23:16];
        hdr.seq_error = (bus_wr.wdata[31:16] != query.seq);
        hdr.rsvd      = 1'b0;
        hdr.upd_time  = bc_time;
    end

    assign mem_wen   = mem_sel;  // Retransmits still rewrite memory
    assign mem_waddr = write_addr;
    assign mem_wdata = (wr_idx == IDX_HEADER) ? reg_data_t'(hdr) : bus_wr.wdata;

    assign num_written = last_waddr + mem_addr_t'(1);  // Wraps to 0 after a query

    always_ff @(posedge sysclk) begin
        if (write_trig_reset) begin
            query         <= '0;
            board_updated <= '0;
            blk_offset    <= '0;
            last_idx      <= IDX_NONE;
            last_waddr    <= '1;
            blk_size      <= '0;
            offset_moved  <= 1'b0;
        end else if (query_pulse) begin
            query         <= query_t'(bus_wr.wdata);
            board_updated <= '0;     // Nobody has reported yet
            blk_offset    <= '0;
            last_idx      <= IDX_NONE;
            last_waddr    <= '1;
            blk_size      <= '0;
            offset_moved  <= 1'b0;
        end else if (mem_sel && new_idx) begin
            last_idx     <= wr_idx;
            last_waddr   <= write_addr;
            offset_moved <= 1'b0;
            if (wr_idx == IDX_HEADER) begin
                blk_size     <= bus_wr.wdata[7:0];
                blk_offset   <= write_addr;  // Offset plus previous size
                offset_moved <= 1'b1;
            end else if (wr_idx == IDX_STATUS) begin
                board_updated[stat_board] <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/hub_trig_sched.sv ====
`include "hub_macros.svh"

module hub_trig_sched
    import hub_bus_pkg::*;
    import hub_bcast_pkg::*;
#(
    parameter bit use_fw = `HUB_USE_FW_DEFAULT  // 0 disables the broadcast trigger
) (
    input  logic        sysclk,
    input  logic        write_trig_reset,
    input  logic        query_pulse,
    input  query_t      query,
    input  board_mask_t board_updated,
    input  board_id_t   board_id,
    input  logic        fw_idle,        // FireWire engine free for a new broadcast
    input  reg_addr_t   raddr,
    output bc_time_t    bc_time,
    output bc_time_t    read_start,     // Timer value when the host began reading
    output board_mask_t mask_lower,
    output logic        updated,
    output logic        write_trig
);

    trig_state_t state;
    logic        pending;   // Query seen and decision due on the next cycle
    logic        selected;  // This board is in the query mask

    // Selected boards with an id below ours
    assign mask_lower = ((board_mask_t'(1) << board_id) - board_mask_t'(1)) & query.board_mask;
    assign selected   = query.board_mask[board_id];
    assign updated    = (board_updated == query.board_mask);  // Empty mask counts as done

    always_ff @(posedge sysclk) begin
        if (write_trig_reset) begin
            bc_time    <= '0;
            read_start <= '0;
            state      <= TRIG_IDLE;
            pending    <= 1'b0;
            write_trig <= 1'b0;
        end else begin
            bc_time <= bc_time + bc_time_t'(1);  // Free running and wraps around
            if (raddr == {`HUB_ADDR_SPACE, 12'h000}) begin
                read_start <= bc_time;           // Start of block read
            end
            if (query_pulse) begin
                bc_time <= '0;
                state   <= TRIG_IDLE;
                pending <= 1'b1;
            end else begin
                case (state)
                    TRIG_IDLE: begin
                        if (pending) begin
                            pending <= 1'b0;
                            if (use_fw && selected) begin
                                state <= (mask_lower == '0) ? TRIG_WAIT_FIRST : TRIG_WAIT_LOWER;
                            end else begin
                                state <= TRIG_DONE;   // Not ours this round
                            end
                        end
                    end
                    TRIG_WAIT_FIRST: begin
                        // Give the PC time to finish its query transaction
                        if (bc_time == bc_time_t'(`HUB_FIRST_DELAY)) begin
                            write_trig <= 1'b1;
                            state      <= TRIG_DONE;
                        end
                    end
                    TRIG_WAIT_LOWER: begin
                        if ((board_updated == mask_lower) && fw_idle) begin
                            write_trig <= 1'b1;
                            state      <= TRIG_DONE;
                        end
                    end
                    default: ;  // TRIG_DONE holds until the next query
                endcase
            end
        end
    end

endmodule

// ==== rtl/hub_read_mux.sv ====
`include "hub_macros.svh"

module hub_read_mux
    import hub_bus_pkg::*;
    import hub_bcast_pkg::*;
(
    input  reg_addr_t   raddr,
    input  query_t      query,
    input  quad_idx_t   last_idx,
    input  mem_addr_t   blk_offset,
    input  mem_addr_t   num_written,
    input  board_id_t   board_id,
    input  board_mask_t mask_lower,
    input  logic        updated,
    input  bc_time_t    bc_time,
    input  bc_time_t    read_start,
    input  reg_data_t   mem_rdata,   // Registered memory output
    output reg_data_t   rdata,
    output logic        rwait        // Requester holds raddr one more cycle
);

    logic      in_hub;      // 0x1xxx
    logic      status_sel;  // 0x1800 to 0x1803
    logic      mem_sel;     // 0x1000 to 0x11FF
    logic      is_extra;    // Timing quadlet after the last block
    logic      addr_ok;     // Index holds written data
    mem_addr_t rd_idx;

    assign rd_idx     = raddr[8:0];
    assign in_hub     = (raddr[15:12] == `HUB_ADDR_SPACE);
    assign status_sel = in_hub && (raddr[11:2] == 10'h200);
    assign mem_sel    = in_hub && (raddr[11:9] == 3'd0);

    // Extra quadlet only once every selected board has reported
    assign is_extra = mem_sel && updated && (rd_idx == num_written);
    assign addr_ok  = mem_sel && (rd_idx < num_written);

    always_comb begin
        rdata = '0;
        rwait = 1'b0;
        if (status_sel) begin
            case (raddr[1:0])
                STAT_QUERY:   rdata = query;
                STAT_OFFSET:  rdata = {8'd0, last_idx, 7'd0, blk_offset};
                STAT_NUMWR:   rdata = {23'd0, num_written};
                default:      rdata = {12'd0, board_id, mask_lower};  // STAT_BOARDID
            endcase
        end else if (is_extra) begin
            rdata = {2'b00, read_start, 2'b00, bc_time};
        end else if (addr_ok) begin
            rdata = mem_rdata;
            rwait = 1'b1;  // RAM needs the extra cycle
        end
    end

endmodule

// ==== rtl/hub_reg.sv ====
`include "hub_macros.svh"

module hub_reg
    import hub_bus_pkg::*;
    import hub_bcast_pkg::*;
#(
    parameter bit use_fw = `HUB_USE_FW_DEFAULT
) (
    input  logic      sysclk,
    input  logic      reg_wen,           // Write strobe, one cycle
    input  reg_addr_t reg_raddr,         // Read address, held by the requester
    input  reg_addr_t reg_waddr,
    input  reg_data_t reg_wdata,
    output reg_data_t reg_rdata,
    output logic      reg_rwait,
    output seq_t      seq_num,           // Sequence from the last query
    input  board_id_t board_id,
    output logic      write_trig,        // Request to broadcast this board's block
    input  logic      write_trig_reset,  // Drops write_trig, clears the hub
    input  logic      fw_idle,
    output logic      updated            // All selected boards have reported
);

    bus_wr_t     bus_wr;
    query_t      query;
    logic        query_pulse;
    board_mask_t board_updated;
    board_mask_t mask_lower;
    mem_addr_t   num_written;
    mem_addr_t   blk_offset;
    quad_idx_t   last_idx;
    logic        mem_wen;
    mem_addr_t   mem_waddr;
    reg_data_t   mem_wdata;
    reg_data_t   mem_rdata;
    bc_time_t    bc_time;
    bc_time_t    read_start;

    assign bus_wr.wen   = reg_wen;
    assign bus_wr.waddr = reg_waddr;
    assign bus_wr.wdata = reg_wdata;
    assign seq_num      = query.seq;

    hub_write_ctrl u_write_ctrl (
        .sysclk, .write_trig_reset, .bus_wr, .bc_time, .query, .query_pulse,
        .board_updated, .num_written, .last_idx, .blk_offset,
        .mem_wen, .mem_waddr, .mem_wdata
    );

    hub_trig_sched #(.use_fw(use_fw)) u_trig_sched (
        .sysclk, .write_trig_reset, .query_pulse, .query, .board_updated, .board_id,
        .fw_idle, .raddr(reg_raddr), .bc_time, .read_start, .mask_lower, .updated,
        .write_trig
    );

    hub_mem u_mem (  // Port A written by the FireWire side, port B read by the host
        .sysclk, .wen(mem_wen), .waddr(mem_waddr), .wdata(mem_wdata),
        .raddr(reg_raddr[8:0]), .rdata(mem_rdata)
    );

    hub_read_mux u_read_mux (
        .raddr(reg_raddr), .query, .last_idx, .blk_offset, .num_written, .board_id,
        .mask_lower, .updated, .bc_time, .read_start, .mem_rdata,
        .rdata(reg_rdata), .rwait(reg_rwait)
    );

endmodule

// ==== test/hub_reg_chk.sv ====
`include "hub_macros.svh"

module hub_reg_chk
    import hub_bus_pkg::*;
    import hub_bcast_pkg::*;
(
    input logic      sysclk,
    input logic      write_trig_reset,
    input logic      write_trig,
    input reg_addr_t reg_raddr,
    input logic      reg_rwait,
    input mem_addr_t num_written
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // Number of assertion failures so far

    // Reset drops the trigger by the next edge
    trig_low_after_reset: assert property (
        @(posedge sysclk) $past(write_trig_reset) |-> !write_trig
    ) else begin
        fail_count++;
        $error("write_trig still high one cycle after write_trig_reset");
    end

    // Only a reset may drop the trigger
    trig_falls_on_reset: assert property (
        @(posedge sysclk) ($past(write_trig) && !write_trig) |-> $past(write_trig_reset)
    ) else begin
        fail_count++;
        $error("write_trig fell without write_trig_reset");
    end

    // Wait flag only for memory indices that hold written data
    rwait_in_range: assert property (
        @(posedge sysclk) disable iff (write_trig_reset)
        reg_rwait |-> (reg_raddr[15:9] == {`HUB_ADDR_SPACE, 3'd0})
                      && (mem_addr_t'(reg_raddr[8:0]) < num_written)
    ) else begin
        fail_count++;
        $error("reg_rwait high outside the written memory range");
    end

endmodule

// ==== test/hub_reg_tb.sv ====
`include "hub_macros.svh"

module hub_reg_tb
    import hub_bus_pkg::*;
    import hub_bcast_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TEST_CYCLES     = 40 + 140 + 420 + 120 + 120;  // Sum of the five tests
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 1160;          // About 2000 cycles

    logic        sysclk;
    logic        reg_wen;
    reg_addr_t   reg_raddr;
    reg_addr_t   reg_waddr;
    reg_data_t   reg_wdata;
    reg_data_t   reg_rdata;
    logic        reg_rwait;
    seq_t        seq_num;
    board_id_t   board_id;
    logic        write_trig;
    logic        write_trig_reset;
    logic        fw_idle;
    logic        updated;

    int          checks = 0;
    int          errors = 0;
    logic [31:0] lcg_state = 32'h9319_9ead;
    reg_data_t   exp_mem [`HUB_MEM_DEPTH];  // Raw quadlets by packed address

    hub_reg DUT (
        .sysclk, .reg_wen, .reg_raddr, .reg_waddr, .reg_wdata, .reg_rdata, .reg_rwait,
        .seq_num, .board_id, .write_trig, .write_trig_reset, .fw_idle, .updated
    );

    bind hub_reg hub_reg_chk u_chk (
        .sysclk, .write_trig_reset, .write_trig, .reg_raddr, .reg_rwait, .num_written
    );

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;  // 4 ns period
    end

    function automatic reg_data_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_val(input string name, input reg_data_t exp, input reg_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("%s done, %0d errors", name, errors - err_start);
    endtask

    task automatic pulse_reset(input int cycles);
        @(posedge sysclk);
        write_trig_reset <= 1'b1;
        repeat (cycles) @(posedge sysclk);
        write_trig_reset <= 1'b0;
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        @(posedge sysclk);
        reg_wen   <= 1'b1;
        reg_waddr <= addr;
        reg_wdata <= data;
        @(posedge sysclk);  // DUT takes the write here
        reg_wen   <= 1'b0;
    endtask

    // Memory reads hold the address a second cycle while rwait is high
    task automatic read_reg(input reg_addr_t addr, output reg_data_t data, output logic wt);
        @(posedge sysclk);
        reg_raddr <= addr;
        @(negedge sysclk);
        wt = reg_rwait;
        if (wt) begin
            @(posedge sysclk);
            @(negedge sysclk);
        end
        data = reg_rdata;
    endtask

    // Header and quadlets 1 to n-1 with the status word naming the board at quadlet 2
    task automatic write_block(input int n, input seq_t hdr_seq, input board_id_t board,
                               input int base);
        reg_data_t data;
        write_reg(16'h1000, {hdr_seq, 8'h00, 8'(n)});
        for (int i = 1; i < n; i++) begin
            data = next_rand();
            if (i == 2) begin
                data[31:24] = {4'h0, board};
            end
            exp_mem[base + i] = data;
            write_reg(16'h1000 + 16'(i), data);
        end
    endtask

    task automatic verify_block(input int n, input seq_t hdr_seq, input seq_t q_seq,
                                input int base);
        reg_data_t   data;
        logic        wt;
        logic [17:0] hdr_hi;  // Header without the time field
        hdr_hi = {8'(n), hdr_seq[7:0], hdr_seq != q_seq, 1'b0};
        read_reg(16'h1000 + 16'(base), data, wt);
        check_val("header[31:14]", 32'(hdr_hi), 32'(data[31:14]));
        for (int i = 1; i < n; i++) begin
            read_reg(16'h1000 + 16'(base + i), data, wt);
            check_val("reg_rwait", 32'd1, 32'(wt));
            check_val("reg_rdata", exp_mem[base + i], data);
        end
    endtask

    task automatic latch_query();
        int          e0;
        seq_t        seq;
        board_mask_t mask;
        reg_data_t   data;
        logic        wt;
        e0   = errors;
        seq  = 16'(next_rand());
        mask = 16'(next_rand()) | 16'h0001;  // Never empty
        write_reg(16'h1800, {seq, mask});
        read_reg(16'h1800, data, wt);
        check_val("query word", {seq, mask}, data);
        check_val("reg_rwait", 32'd0, 32'(wt));
        read_reg(16'h1802, data, wt);
        check_val("num_written", 32'd0, data);
        check_val("seq_num", 32'(seq), 32'(seq_num));
        check_val("write_trig", 32'd0, 32'(write_trig));
        check_val("updated", 32'd0, 32'(updated));
        report_test("query_latch", e0);
    endtask

    task automatic pack_blocks();
        int        e0;
        int        na;
        int        nb;
        seq_t      seq;
        reg_data_t data;
        logic      wt;
        e0 = errors;
        pulse_reset(1);
        seq = 16'(next_rand());
        na  = 4 + int'(next_rand() % 5);
        nb  = 3 + int'(next_rand() % 6);
        write_reg(16'h1800, {seq, 16'h0003});
        write_block(na, seq, 4'd0, 0);
        write_block(nb, seq ^ 16'h0100, 4'd1, na);  // Wrong high byte sets seq_error
        verify_block(na, seq, seq, 0);
        verify_block(nb, seq ^ 16'h0100, seq, na);  // Packed right after block A
        read_reg(16'h1801, data, wt);
        check_val("last idx and offset", {8'd0, 8'(nb - 1), 7'd0, 9'(na)}, data);
        read_reg(16'h1802, data, wt);
        check_val("num_written", 32'(na + nb), data);
        report_test("block_packing", e0);
    endtask

    task automatic fire_first_board();
        int   e0;
        logic seen;
        e0   = errors;
        seen = 1'b0;
        pulse_reset(1);
        board_id <= 4'd0;
        write_reg(16'h1800, {16'(next_rand()), 16'h0005});
        repeat (`HUB_FIRST_DELAY) @(posedge sysclk);
        @(negedge sysclk);
        check_val("write_trig before delay", 32'd0, 32'(write_trig));
        @(posedge sysclk);
        @(negedge sysclk);
        check_val("write_trig at delay", 32'd1, 32'(write_trig));
        pulse_reset(1);
        @(negedge sysclk);
        check_val("write_trig after reset", 32'd0, 32'(write_trig));
        repeat (200) begin
            @(negedge sysclk);
            seen = seen | write_trig;  // Must not come back without a query
        end
        check_val("write_trig retrigger", 32'd0, 32'(seen));
        report_test("first_trigger", e0);
    endtask

    task automatic fire_in_order();
        int        e0;
        seq_t      seq;
        reg_data_t data;
        logic      wt;
        e0 = errors;
        pulse_reset(1);
        board_id <= 4'd2;
        fw_idle  <= 1'b1;
        seq = 16'(next_rand());
        write_reg(16'h1800, {seq, 16'h0007});
        read_reg(16'h1803, data, wt);
        check_val("board id and lower mask", {12'd0, 4'd2, 16'h0003}, data);
        write_block(3, seq, 4'd0, 0);
        repeat (3) @(posedge sysclk);
        @(negedge sysclk);
        check_val("write_trig after board 0", 32'd0, 32'(write_trig));
        @(posedge sysclk);
        fw_idle <= 1'b0;  // Bus busy while board 1 reports
        write_block(3, seq, 4'd1, 3);
        repeat (3) @(posedge sysclk);
        @(negedge sysclk);
        check_val("write_trig while busy", 32'd0, 32'(write_trig));
        @(posedge sysclk);
        fw_idle <= 1'b1;
        @(negedge sysclk);
        check_val("write_trig same cycle", 32'd0, 32'(write_trig));
        @(posedge sysclk);
        @(negedge sysclk);
        check_val("write_trig next cycle", 32'd1, 32'(write_trig));
        report_test("ordered_trigger", e0);
    endtask

    task automatic complete_round();
        int        e0;
        seq_t      seq;
        reg_data_t data;
        logic      wt;
        e0 = errors;
        pulse_reset(1);
        board_id <= 4'd4;
        fw_idle  <= 1'b0;
        @(negedge sysclk);
        check_val("updated with empty mask", 32'd1, 32'(updated));
        seq = 16'(next_rand());
        write_reg(16'h1800, {seq, 16'h0013});  // Boards 0, 1 and 4
        write_block(3, seq, 4'd0, 0);
        write_block(4, seq, 4'd1, 3);
        @(negedge sysclk);
        check_val("updated before board 4", 32'd0, 32'(updated));
        write_block(5, seq, 4'd4, 7);
        @(negedge sysclk);
        check_val("updated", 32'd1, 32'(updated));
        read_reg(16'h1802, data, wt);
        check_val("num_written", 32'd12, data);
        read_reg(16'h1000 + 16'd12, data, wt);   // Timing quadlet
        check_val("extra reg_rwait", 32'd0, 32'(wt));
        check_val("extra timer nonzero", 32'd1, 32'(data[13:0] != 14'd0));
        read_reg(16'h1000 + 16'd13, data, wt);
        check_val("beyond extra rdata", 32'd0, data);
        check_val("beyond extra reg_rwait", 32'd0, 32'(wt));
        report_test("completion", e0);
    endtask

    initial begin
        reg_wen          = 1'b0;
        reg_raddr        = '0;
        reg_waddr        = '0;
        reg_wdata        = '0;
        board_id         = 4'd7;
        fw_idle          = 1'b1;
        write_trig_reset = 1'b1;
        repeat (5) @(posedge sysclk);
        write_trig_reset <= 1'b0;
        latch_query();
        pack_blocks();
        fire_first_board();
        fire_in_order();
        complete_round();
        errors += DUT.u_chk.fail_count;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sysclk);
        $display("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
rtl/hub_bus_pkg.sv
rtl/hub_bcast_pkg.sv
rtl/hub_mem.sv
rtl/hub_write_ctrl.sv
rtl/hub_trig_sched.sv
rtl/hub_read_mux.sv
rtl/hub_reg.sv
test/hub_reg_chk.sv
test/hub_reg_tb.sv

// ==== Bender.yml ====
package:
  name: hub_reg

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/hub_bus_pkg.sv
      - rtl/hub_bcast_pkg.sv
      - rtl/hub_mem.sv
      - rtl/hub_write_ctrl.sv
      - rtl/hub_trig_sched.sv
      - rtl/hub_read_mux.sv
      - rtl/hub_reg.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/hub_reg_chk.sv
      - test/hub_reg_tb.sv
